// File: verilog.f
+incdir+include
src/ring_pkg.sv
src/uart_frame_tx.sv
src/uart_frame_rx.sv
src/bram_slave.sv
src/node_ctrl.sv
src/ring_node.sv
src/ring_top.sv
sim/ring_props.sv
sim/ring_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ring memory testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module ring_tb -f verilog.f -o ring_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/ring_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/ring_patterns.txt
# columns: issuing node, op, target node, addr (hex), write data (hex), expected read (hex)
# W and R run one at a time, a run of w and r lines from distinct nodes is issued together
0 W 0 010 a5 00
0 R 0 010 00 a5
1 W 1 010 3c 00
1 R 1 010 00 3c
2 W 2 010 c3 00
2 R 2 010 00 c3
0 R 1 0ff 00 00
1 R 2 0ff 00 00
2 R 0 0ff 00 00
0 W 2 100 5a 00
1 R 2 100 00 5a
2 R 2 100 00 5a
0 R 0 100 00 00
1 R 0 010 00 a5
0 R 2 010 00 c3
2 R 1 010 00 3c
0 w 1 080 61 00
1 w 2 081 62 00
2 w 0 082 63 00
0 r 2 081 00 62
1 r 0 082 00 63
2 r 1 080 00 61
0 W 0 000 01 00
1 W 1 1ff 12 00
2 W 0 1ff 20 00
1 W 2 000 21 00
0 W 1 000 10 00
2 W 2 1ff 22 00
0 R 0 000 00 01
1 R 0 1ff 00 20
2 R 1 000 00 10
1 R 1 1ff 00 12
0 R 2 000 00 21
2 R 2 1ff 00 22
2 R 0 000 00 01
0 R 1 1ff 00 12

// File: sim/ring_tb.sv
/*
 ring memory testbench
 replays access patterns on the host ports of the three nodes
 and checks read data against the pattern file and a memory model
*/

`timescale 1ns/1ps
`include "ring_defs.svh"

module ring_tb import ring_pkg::*; ();

	// one line of the pattern file
	typedef struct packed {
		node_id_t   src;
		logic [7:0] op;
		node_id_t   dst;
		mem_addr_t  addr;
		mem_data_t  data;
		mem_data_t  exp_data;
	} pattern_t;

	logic                        clock;
	logic                        rst;
	host_req_t [`RING_NODES-1:0] host_req;
	host_rsp_t [`RING_NODES-1:0] host_rsp;

	pattern_t    pats[$];
	mem_data_t   model [`RING_NODES][`RING_MEM_DEPTH];
	logic [31:0] rng_state;
	int          cycle_count;
	int          cycle_limit = 1000;
	int          data_errors;
	int          model_errors;
	int          latency_errors;

	ring_top DUT (
		.clock(clock),
		.rst(rst),
		.host_req(host_req),
		.host_rsp(host_rsp)
	);

	bind node_ctrl ring_props u_props (
		.clock(clock),
		.rst(rst),
		.host_rsp(host_rsp),
		.rx_valid(rx_valid),
		.rx_mine(rx_mine),
		.hold_valid(hold_valid),
		.tx_ready(tx_ready),
		.tx_start(tx_start)
	);

	// 100 ns clock
	always #50 clock = ~clock;

	// run limit, sized from the pattern count
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, a host access never completed", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// xorshift32 step on the shared state
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic load_patterns();
		int          fd;
		int          n;
		string       line;
		int          src;
		int          dst;
		logic [7:0]  op;
		int unsigned addr;
		int unsigned data;
		int unsigned exp_data;
		pattern_t    p;
		fd = $fopen("sim/ring_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open pattern file sim/ring_patterns.txt");
		end else begin
			// comment lines fail the first field and are skipped
			while ($fgets(line, fd) > 0) begin
				n = $sscanf(line, "%d %c %d %h %h %h", src, op, dst, addr, data, exp_data);
				if (n == 6) begin
					p.src      = node_id_t'(src);
					p.op       = op;
					p.dst      = node_id_t'(dst);
					p.addr     = mem_addr_t'(addr);
					p.data     = mem_data_t'(data);
					p.exp_data = mem_data_t'(exp_data);
					pats.push_back(p);
				end
			end
			$fclose(fd);
		end
	endtask

	// one Wishbone classic cycle on a host port
	task automatic host_access(input node_id_t n, input logic we, input node_id_t tgt,
		input mem_addr_t addr, input mem_data_t wdat, output mem_data_t rdat,
		output int lat);
		@(posedge clock);
		host_req[n] <= '{cyc: 1'b1, stb: 1'b1, we: we, node: tgt, addr: addr, dat: wdat};
		lat = 0;
		// sample on the falling edge, away from the DUT updates
		@(negedge clock);
		while (!host_rsp[n].ack) begin
			lat++;
			@(negedge clock);
		end
		rdat = host_rsp[n].dat;
		@(posedge clock);
		host_req[n].cyc <= 1'b0;
		host_req[n].stb <= 1'b0;
	endtask

	task automatic run_pattern(input int idx, input int gap, input bit seq);
		pattern_t  p;
		mem_data_t rdat;
		int        lat;
		logic      we;
		p  = pats[idx];
		we = (p.op == "W") || (p.op == "w");
		repeat (gap) @(posedge clock);
		host_access(p.src, we, p.dst, p.addr, p.data, rdat, lat);
		if (we) begin
			model[p.dst][p.addr] = p.data;
		end else begin
			assert (rdat == p.exp_data) else begin
				data_errors++;
				$display("FAIL %0t: node %0d read node %0d addr 0x%03h got 0x%02h, file 0x%02h",
					$time, p.src, p.dst, p.addr, rdat, p.exp_data);
			end
			assert (rdat == model[p.dst][p.addr]) else begin
				model_errors++;
				$display("FAIL %0t: node %0d read node %0d addr 0x%03h got 0x%02h, model 0x%02h",
					$time, p.src, p.dst, p.addr, rdat, model[p.dst][p.addr]);
			end
		end
		// local access timing only holds on a quiet ring
		if (seq && (p.src == p.dst)) begin
			assert (lat == 3) else begin
				latency_errors++;
				$display("FAIL %0t: node %0d local access acked after %0d cycles, expected 3",
					$time, p.src, lat);
			end
		end
	endtask

	initial begin
		int                     i;
		int                     j;
		int                     gsize;
		logic [`RING_NODES-1:0] used;
		clock          = 1'b0;
		rst            = 1'b1;
		host_req       = '0;
		rng_state      = 32'd73140;
		cycle_count    = 0;
		data_errors    = 0;
		model_errors   = 0;
		latency_errors = 0;
		for (int n = 0; n < `RING_NODES; n++) begin
			for (int a = 0; a < `RING_MEM_DEPTH; a++) begin
				model[n][a] = '0;
			end
		end
		load_patterns();
		cycle_limit = 600 * pats.size() + 1000;
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		i = 0;
		while (i < pats.size()) begin
			if (pats[i].op == "r" || pats[i].op == "w") begin
				// group ends at the first repeated node
				j    = i;
				used = '0;
				while (j < pats.size() && (pats[j].op == "r" || pats[j].op == "w") &&
					!used[pats[j].src]) begin
					used[pats[j].src] = 1'b1;
					j++;
				end
				gsize = j - i;
				fork
					if (gsize > 0) run_pattern(i, 0, 1'b0);
					if (gsize > 1) run_pattern(i + 1, 0, 1'b0);
					if (gsize > 2) run_pattern(i + 2, 0, 1'b0);
				join
				i = j;
			end else begin
				run_pattern(i, int'(next_random() % 32'd4), 1'b1);
				i++;
			end
		end
		repeat (4) @(posedge clock);
		$display("errors: data %0d, model %0d, latency %0d, patterns run %0d",
			data_errors, model_errors, latency_errors, pats.size());
		if (pats.size() > 0 && data_errors + model_errors + latency_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: sim/ring_props.sv
/*
 node controller checks
 single cycle host ack, hold register overflow, tx start taken by the transmitter
*/

`timescale 1ns/1ps

module ring_props import ring_pkg::*; (
	input logic      clock,
	input logic      rst,
	input host_rsp_t host_rsp,
	input logic      rx_valid,
	input logic      rx_mine,
	input logic      hold_valid,
	input logic      tx_ready,
	input logic      tx_start
);

	// ack is a one cycle pulse
	ack_single: assert property (@(posedge clock) disable iff (rst)
		host_rsp.ack |=> !host_rsp.ack)
		else $error("host ack stayed high for two cycles");

	// frame for the hold register while it is full and tx busy would be lost
	hold_overflow: assert property (@(posedge clock) disable iff (rst)
		(rx_valid && !rx_mine && hold_valid) |-> tx_ready)
		else $error("ring frame arrived with hold register full and tx busy");

	// a start is taken, so the transmitter goes busy next cycle
	start_ready: assert property (@(posedge clock) disable iff (rst)
		tx_start |=> !tx_ready)
		else $error("tx_start was not taken, the transmitter stayed ready");

endmodule

// File: src/ring_top.sv
/*
 three node memory ring
 each node's tx line drives the next node's rx line, closing the loop
*/

`timescale 1ns/1ps
`include "ring_defs.svh"

module ring_top import ring_pkg::*; (
	input  logic                          clock,
	input  logic                          rst,
	input  host_req_t [`RING_NODES-1:0] host_req,
	output host_rsp_t [`RING_NODES-1:0] host_rsp
);

	// ring_line[i] is the tx of node i
	logic [`RING_NODES-1:0] ring_line;

	ring_node #(
		.NODE_ID(2'd0)
	) node_0 (
		.clock(clock),
		.rst(rst),
		.host_req(host_req[0]),
		.host_rsp(host_rsp[0]),
		.rx(ring_line[2]),
		.tx(ring_line[0])
	);

	ring_node #(
		.NODE_ID(2'd1)
	) node_1 (
		.clock(clock),
		.rst(rst),
		.host_req(host_req[1]),
		.host_rsp(host_rsp[1]),
		.rx(ring_line[0]),
		.tx(ring_line[1])
	);

	// last node feeds back into node 0
	ring_node #(
		.NODE_ID(2'd2)
	) node_2 (
		.clock(clock),
		.rst(rst),
		.host_req(host_req[2]),
		.host_rsp(host_rsp[2]),
		.rx(ring_line[1]),
		.tx(ring_line[2])
	);

endmodule

// File: src/ring_node.sv
/*
 one ring node
 controller with its RAM, frame transmitter and frame receiver
*/

`timescale 1ns/1ps

module ring_node import ring_pkg::*; #(
	parameter node_id_t NODE_ID = '0
) (
	input  logic      clock,
	input  logic      rst,
	input  host_req_t host_req,
	output host_rsp_t host_rsp,
	input  logic      rx,
	output logic      tx
);

	mem_req_t    mem_req;
	mem_rsp_t    mem_rsp;
	logic        rx_valid;
	ring_frame_t rx_frame;
	logic        tx_start;
	ring_frame_t tx_frame;
	logic        tx_ready;

	node_ctrl #(
		.NODE_ID(NODE_ID)
	) u_ctrl (
		.clock(clock),
		.rst(rst),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp),
		.rx_valid(rx_valid),
		.rx_frame(rx_frame),
		.tx_start(tx_start),
		.tx_frame(tx_frame),
		.tx_ready(tx_ready)
	);

	bram_slave u_ram (
		.clock(clock),
		.rst(rst),
		.req(mem_req),
		.rsp(mem_rsp)
	);

	// outgoing link to the next node
	uart_frame_tx u_tx (
		.clock(clock),
		.rst(rst),
		.start(tx_start),
		.frame(tx_frame),
		.ready(tx_ready),
		.tx(tx)
	);

	// incoming link from the previous node
	uart_frame_rx u_rx (
		.clock(clock),
		.rst(rst),
		.rx(rx),
		.valid(rx_valid),
		.frame(rx_frame)
	);

endmodule

// File: src/node_ctrl.sv
/*
 ring node controller
 serves the host port, the local RAM and frames arriving from the ring
 remote accesses leave as request frames and finish on the response
*/

`timescale 1ns/1ps

module node_ctrl import ring_pkg::*; #(
	parameter node_id_t NODE_ID = '0
) (
	input  logic        clock,
	input  logic        rst,
	input  host_req_t   host_req,
	output host_rsp_t   host_rsp,
	output mem_req_t    mem_req,
	input  mem_rsp_t    mem_rsp,
	input  logic        rx_valid,
	input  ring_frame_t rx_frame,
	output logic        tx_start,
	output ring_frame_t tx_frame,
	input  logic        tx_ready
);

	ctrl_state_t state;
	logic        host_wait;
	logic        hold_valid;
	ring_frame_t hold_frame;
	ring_frame_t req_frame;
	logic        rsp_hit;
	mem_data_t   rsp_data;
	logic        rx_mine;
	logic        hold_serve;
	logic        host_new;

	// response to our own outstanding access
	assign rx_mine    = rx_valid && rx_frame.is_rsp && (rx_frame.dst == NODE_ID);
	// request addressed here, needs the RAM
	assign hold_serve = !hold_frame.is_rsp && (hold_frame.dst == NODE_ID);
	assign host_new   = host_req.cyc && host_req.stb;

	assign tx_start = tx_ready &&
		(state == SEND_REQ || state == SEND_RSP || state == FORWARD);
	assign tx_frame = (state == SEND_REQ) ? req_frame : hold_frame;

	always_ff @(posedge clock) begin
		if (rst) begin
			state        <= IDLE;
			host_wait    <= 1'b0;
			hold_valid   <= 1'b0;
			rsp_hit      <= 1'b0;
			host_rsp.ack <= 1'b0;
			mem_req.cyc  <= 1'b0;
			mem_req.stb  <= 1'b0;
		end else begin
			host_rsp.ack <= 1'b0;
			case (state)
				IDLE, WAIT_RSP: begin
					if (hold_valid) begin
						// held frame goes before the host
						if (hold_serve) begin
							mem_req <= '{cyc: 1'b1, stb: 1'b1, we: hold_frame.we,
								addr: hold_frame.addr, dat: hold_frame.data};
							state   <= SERVE;
						end else begin
							state <= FORWARD;
						end
					end else if (state == WAIT_RSP) begin
						if (rsp_hit) begin
							rsp_hit      <= 1'b0;
							host_wait    <= 1'b0;
							host_rsp.ack <= 1'b1;
							host_rsp.dat <= rsp_data;
							state        <= DONE;
						end
					end else if (host_new && !rx_valid) begin
						if (host_req.node == NODE_ID) begin
							mem_req <= '{cyc: 1'b1, stb: 1'b1, we: host_req.we,
								addr: host_req.addr, dat: host_req.dat};
							state   <= LOCAL;
						end else if (tx_ready) begin
							req_frame <= '{is_rsp: 1'b0, src: NODE_ID, dst: host_req.node,
								we: host_req.we, addr: host_req.addr, data: host_req.dat,
								spare: 1'b0};
							host_wait <= 1'b1;
							state     <= SEND_REQ;
						end
					end
				end
				LOCAL: begin
					if (mem_rsp.ack) begin
						mem_req.cyc  <= 1'b0;
						mem_req.stb  <= 1'b0;
						host_rsp.ack <= 1'b1;
						host_rsp.dat <= mem_rsp.dat;
						state        <= DONE;
					end
				end
				SEND_REQ: begin
					if (tx_ready) begin
						state <= WAIT_RSP;
					end
				end
				SERVE: begin
					if (mem_rsp.ack) begin
						mem_req.cyc       <= 1'b0;
						mem_req.stb       <= 1'b0;
						// turn the request around toward its origin
						hold_frame.is_rsp <= 1'b1;
						hold_frame.src    <= NODE_ID;
						hold_frame.dst    <= hold_frame.src;
						if (!hold_frame.we) begin
							hold_frame.data <= mem_rsp.dat;
						end
						state <= SEND_RSP;
					end
				end
				SEND_RSP, FORWARD: begin
					if (tx_ready) begin
						hold_valid <= 1'b0;
						state      <= host_wait ? WAIT_RSP : IDLE;
					end
				end
				DONE: begin
					// wait for the host to end its cycle
					if (!host_req.stb) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
			// arrivals last, a new frame refills hold in the cycle it drains
			if (rx_valid) begin
				if (rx_mine) begin
					rsp_hit  <= 1'b1;
					rsp_data <= rx_frame.data;
				end else begin
					hold_valid <= 1'b1;
					hold_frame <= rx_frame;
				end
			end
		end
	end

endmodule

// File: src/bram_slave.sv
/*
 node RAM
 Wishbone classic slave around a 512x8 block RAM, one cycle ack
*/

`timescale 1ns/1ps
`include "ring_defs.svh"

module bram_slave import ring_pkg::*; (
	input  logic     clock,
	input  logic     rst,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	mem_data_t mem [`RING_MEM_DEPTH];
	logic      ack_q;
	mem_data_t dat_q;
	logic      hit;

	// new strobe only, not the cycle already acked
	assign hit = req.cyc && req.stb && !ack_q;
	assign rsp = '{ack: ack_q, dat: dat_q};

	// contents start cleared
	initial begin
		for (int i = 0; i < `RING_MEM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	// read data lands with ack
	always_ff @(posedge clock) begin
		if (hit) begin
			if (req.we) begin
				mem[req.addr] <= req.dat;
			end
			dat_q <= mem[req.addr];
		end
	end

endmodule

// File: src/uart_frame_rx.sv
/*
 ring frame receiver
 samples a UART line mid-bit and rebuilds three bytes into one frame
*/

`timescale 1ns/1ps
`include "ring_defs.svh"

module uart_frame_rx import ring_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  logic        rx,
	output logic        valid,
	output ring_frame_t frame
);

	localparam int CPB = `RING_CLKS_PER_BIT;
	localparam int TW  = $clog2(CPB);
	localparam int FW  = $bits(ring_frame_t);
	// two sync flops eat part of the bit, so sample a little early
	localparam logic [TW-1:0] TMR_MID  = TW'(CPB / 2 - 1);
	localparam logic [TW-1:0] TMR_LAST = TW'(CPB - 1);
	localparam logic [1:0]    BYTE_LAST = 2'(`RING_FRAME_BYTES - 1);

	logic [1:0]    rx_sync;
	logic          rx_s;
	logic          busy;
	logic [TW-1:0] bit_tmr;
	logic [3:0]    bit_idx;
	logic [1:0]    byte_idx;
	logic [7:0]    byte_sh;
	logic [FW-1:0] asm_q;

	assign rx_s  = rx_sync[1];
	assign frame = ring_frame_t'(asm_q);

	always_ff @(posedge clock) begin
		if (rst) begin
			rx_sync  <= 2'b11;
			busy     <= 1'b0;
			valid    <= 1'b0;
			bit_tmr  <= '0;
			bit_idx  <= '0;
			byte_idx <= '0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			valid   <= 1'b0;
			if (!busy) begin
				bit_tmr  <= '0;
				bit_idx  <= '0;
				byte_idx <= '0;
				// falling edge into a start bit
				busy     <= !rx_s;
			end else begin
				bit_tmr <= (bit_tmr == TMR_LAST) ? '0 : bit_tmr + 1'b1;
				if (bit_tmr == TMR_MID) begin
					bit_idx <= (bit_idx == 4'd9) ? 4'd0 : bit_idx + 1'b1;
					if (bit_idx == 4'd0) begin
						// glitch, not a start bit
						if (rx_s) begin
							busy <= 1'b0;
						end
					end else if (bit_idx == 4'd9) begin
						if (!rx_s) begin
							// bad stop bit, drop partial frame
							busy <= 1'b0;
						end else begin
							asm_q    <= {byte_sh, asm_q[FW-1:8]};
							byte_idx <= byte_idx + 1'b1;
							if (byte_idx == BYTE_LAST) begin
								busy  <= 1'b0;
								valid <= 1'b1;
							end
						end
					end else begin
						// data bits arrive LSB first
						byte_sh <= {rx_s, byte_sh[7:1]};
					end
				end
			end
		end
	end

endmodule

// File: src/uart_frame_tx.sv
/*
 ring frame transmitter
 sends one frame as three back to back UART bytes, LSB first
*/

`timescale 1ns/1ps
`include "ring_defs.svh"

module uart_frame_tx import ring_pkg::*; (
	input  logic        clock,
	input  logic        rst,
	input  logic        start,
	input  ring_frame_t frame,
	output logic        ready,
	output logic        tx
);

	localparam int CPB   = `RING_CLKS_PER_BIT;
	localparam int TW    = $clog2(CPB);
	localparam int NBITS = `RING_FRAME_BYTES * 10;
	localparam int CW    = $clog2(NBITS);
	localparam logic [TW-1:0] TMR_LAST = TW'(CPB - 1);
	localparam logic [CW-1:0] BIT_LAST = CW'(NBITS - 1);

	logic                           busy;
	logic [TW-1:0]                  bit_tmr;
	logic [CW-1:0]                  bit_cnt;
	logic [NBITS-1:0]               shreg;
	logic [NBITS-1:0]               pattern;
	logic [$bits(ring_frame_t)-1:0] fbits;

	assign fbits = frame;

	// stop, data, start per byte
	always_comb begin
		for (int i = 0; i < `RING_FRAME_BYTES; i++) begin
			pattern[i*10 +: 10] = {1'b1, fbits[i*8 +: 8], 1'b0};
		end
	end

	assign ready = !busy;
	// line idles high
	assign tx = busy ? shreg[0] : 1'b1;

	always_ff @(posedge clock) begin
		if (rst) begin
			busy    <= 1'b0;
			bit_tmr <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			bit_tmr <= '0;
			bit_cnt <= '0;
			if (start) begin
				busy  <= 1'b1;
				shreg <= pattern;
			end
		end else if (bit_tmr == TMR_LAST) begin
			// end of one bit time
			bit_tmr <= '0;
			shreg   <= {1'b1, shreg[NBITS-1:1]};
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == BIT_LAST) begin
				busy <= 1'b0;
			end
		end else begin
			bit_tmr <= bit_tmr + 1'b1;
		end
	end

endmodule

// File: src/ring_pkg.sv
/*
 ring memory node types
 frame layout, host and RAM Wishbone bundles, controller states
*/

`include "ring_defs.svh"

package ring_pkg;

	typedef logic [$clog2(`RING_NODES)-1:0]     node_id_t;
	typedef logic [$clog2(`RING_MEM_DEPTH)-1:0] mem_addr_t;
	typedef logic [7:0]                         mem_data_t;

	// 24 bits on the wire, lowest byte first
	typedef struct packed {
		logic      is_rsp;
		node_id_t  src;
		node_id_t  dst;
		logic      we;
		mem_addr_t addr;
		mem_data_t data;
		logic      spare;
	} ring_frame_t;

	// host side Wishbone classic
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		node_id_t  node;
		mem_addr_t addr;
		mem_data_t dat;
	} host_req_t;

	typedef struct packed {
		logic      ack;
		mem_data_t dat;
	} host_rsp_t;

	// controller to RAM
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		mem_addr_t addr;
		mem_data_t dat;
	} mem_req_t;

	typedef struct packed {
		logic      ack;
		mem_data_t dat;
	} mem_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		LOCAL,
		SEND_REQ,
		WAIT_RSP,
		SERVE,
		SEND_RSP,
		FORWARD,
		DONE
	} ctrl_state_t;

endpackage

// File: include/ring_defs.svh
/*
 ring memory node parameters
 UART bit timing, ring size, per-node RAM depth and frame length
*/

`ifndef RING_DEFS_SVH
`define RING_DEFS_SVH

// clocks per UART bit, kept short for simulation
`define RING_CLKS_PER_BIT 4

// nodes in the loop
`define RING_NODES 3

// 8-bit words per node RAM
`define RING_MEM_DEPTH 512

// bytes per ring frame
`define RING_FRAME_BYTES 3

`endif
